// ==== all.f ====
verilog/ooo_pkg.sv
verilog/rs.sv
verilog/rename_table.sv
verilog/rob.sv
verilog/exec_units.sv
verilog/ooo_core.sv
testbench/ooo_core_properties.sv
testbench/ooo_core_tb.sv

// ==== testbench/ooo_core_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module ooo_core_properties (
    input logic                 clock,
    input logic                 reset,
    input ooo_pkg::dp_packet_t  dp_packet,
    input logic                 dispatch_accept,
    input logic                 commit_valid,
    input ooo_pkg::cdb_packet_t cdb_packet
);

    int failures = 0;  // Count of failed assertions

    // Strobes must be clean once out of reset
    commit_known: assert property (@(posedge clock) disable iff (reset)
        !$isunknown(commit_valid))
        else begin
            failures++;
            $error("commit_valid is unknown");
        end

    bus_known: assert property (@(posedge clock) disable iff (reset)
        !$isunknown(cdb_packet.valid))
        else begin
            failures++;
            $error("cdb_packet.valid is unknown");
        end

    // Accept only answers a valid dispatch
    accept_needs_valid: assert property (@(posedge clock) disable iff (reset)
        dispatch_accept |-> dp_packet.valid)
        else begin
            failures++;
            $error("dispatch_accept without dp_packet.valid");
        end

    no_commit_in_reset: assert property (@(posedge clock) reset |-> !commit_valid)
        else begin
            failures++;
            $error("commit_valid high during reset");
        end

endmodule

bind ooo_core ooo_core_properties u_properties (
    .clock           (clock),
    .reset           (reset),
    .dp_packet       (dp_packet),
    .dispatch_accept (dispatch_accept),
    .commit_valid    (commit_valid),
    .cdb_packet      (cdb_packet)
);

`default_nettype wire

// ==== testbench/ooo_core_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module ooo_core_tb;

    logic                    clock;
    logic                    reset;
    ooo_pkg::dp_packet_t     dp_packet;
    logic                    dispatch_accept;
    logic                    commit_valid;
    ooo_pkg::commit_packet_t commit_packet;
    ooo_pkg::cdb_packet_t    cdb_packet;

    logic [31:0]             ref_regs [32];  // Architectural state in program order
    ooo_pkg::commit_packet_t expected [$];   // Outstanding commits, oldest first
    logic [31:0]             bus_exp [ooo_pkg::rob_depth];  // Expected bus value per ROB tag
    int seed, checks, errors, err_base, dispatched, committed, refused, bus_results;
    string chain_ops [5] = '{"add", "sub", "mul", "xor", "addi"};
    string mnems [10] = '{"add", "sub", "and", "or", "xor",
                          "addi", "andi", "ori", "xori", "mul"};

    ooo_core dut (
        .clock           (clock),
        .reset           (reset),
        .dp_packet       (dp_packet),
        .dispatch_accept (dispatch_accept),
        .commit_valid    (commit_valid),
        .commit_packet   (commit_packet),
        .cdb_packet      (cdb_packet)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;  // 20 ns period
    end

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] exp_val);
        checks++;
        if (actual !== exp_val) begin
            errors++;
            $display("[ERROR] t=%0t %s actual=0x%08h expected=0x%08h",
                     $time, name, actual, exp_val);
        end
    endtask

    // RV32 encoder for the supported mnemonics
    function automatic logic [31:0] make_inst(input string mn, input ooo_pkg::reg_idx_t rd,
                                              input ooo_pkg::reg_idx_t rs1,
                                              input ooo_pkg::reg_idx_t rs2,
                                              input logic [11:0] imm);
        case (mn)
            "add":   return {7'h00, rs2, rs1, 3'b000, rd, 7'b0110011};
            "sub":   return {7'h20, rs2, rs1, 3'b000, rd, 7'b0110011};
            "mul":   return {7'h01, rs2, rs1, 3'b000, rd, 7'b0110011};
            "and":   return {7'h00, rs2, rs1, 3'b111, rd, 7'b0110011};
            "or":    return {7'h00, rs2, rs1, 3'b110, rd, 7'b0110011};
            "xor":   return {7'h00, rs2, rs1, 3'b100, rd, 7'b0110011};
            "addi":  return {imm, rs1, 3'b000, rd, 7'b0010011};
            "andi":  return {imm, rs1, 3'b111, rd, 7'b0010011};
            "ori":   return {imm, rs1, 3'b110, rd, 7'b0010011};
            default: return {imm, rs1, 3'b100, rd, 7'b0010011};  // xori
        endcase
    endfunction

    // Reference model, one instruction in program order
    function automatic ooo_pkg::commit_packet_t ref_step(input logic [31:0] word);
        logic [63:0]             prod;
        logic [31:0]             a, b, r;
        ooo_pkg::commit_packet_t c;
        a = ref_regs[word[19:15]];
        b = (word[6:0] == 7'b0010011) ? {{20{word[31]}}, word[31:20]} : ref_regs[word[24:20]];
        prod = {32'd0, a} * {32'd0, b};
        case (word[14:12])
            3'b100:  r = a ^ b;
            3'b110:  r = a | b;
            3'b111:  r = a & b;
            default: begin
                if (word[6:0] == 7'b0110011 && word[31:25] == 7'h01) begin
                    r = prod[31:0];  // MUL low word
                end else if (word[6:0] == 7'b0110011 && word[30]) begin
                    r = a - b;
                end else begin
                    r = a + b;
                end
            end
        endcase
        c.rd       = word[11:7];
        c.has_dest = word[11:7] != 5'd0;
        c.value    = r;
        if (c.has_dest) ref_regs[word[11:7]] = r;  // x0 stays zero
        return c;
    endfunction

    // Hold the word until accepted, accept sampled mid-cycle
    task automatic dispatch(input logic [31:0] word);
        int                      waited;
        logic                    taken;
        ooo_pkg::commit_packet_t c;
        waited = 0;
        taken  = 1'b0;
        dp_packet.valid = 1'b1;
        dp_packet.inst  = word;
        while (!taken && waited < 200) begin
            @(negedge clock);
            if (dispatch_accept) begin
                taken = 1'b1;
                c = ref_step(word);
                bus_exp[dispatched % ooo_pkg::rob_depth] = c.value;  // Tags go out in order
                expected.push_back(c);
                dispatched++;
            end else begin
                refused++;  // Back-pressure seen
            end
            @(posedge clock);
            #2;
            waited++;
        end
        dp_packet.valid = 1'b0;
        if (!taken) begin
            $display("Timeout: instruction 0x%08h was never accepted", word);
            $display("CHECKS FAILED");
            $finish;
        end
    endtask

    task automatic drain(input string name);
        int waited;
        waited = 0;
        while (expected.size() != 0 && waited < 1000) begin
            @(posedge clock);
            #2;
            waited++;
        end
        if (expected.size() != 0) begin
            $display("Timeout: %0d commits missing in test %s", expected.size(), name);
            $display("CHECKS FAILED");
            $finish;
        end
    endtask

    // Quiet cycles after retirement, a stray commit or bus result shows up here
    task automatic idle(input int cycles);
        repeat (cycles) @(posedge clock);
        #2;
    endtask

    task automatic report_test(input string name);
        $display("test %-8s finished, %0d new errors", name, errors - err_base);
        err_base = errors;
    endtask

    // Commit checker, outputs are settled at the falling edge
    initial begin
        ooo_pkg::commit_packet_t exp_c;
        forever begin
            @(negedge clock);
            if (!reset && commit_valid) begin
                committed++;
                if (expected.size() == 0) begin
                    errors++;
                    $display("Commit at %0t with no instruction outstanding", $time);
                end else begin
                    exp_c = expected.pop_front();
                    check("commit_packet.rd", commit_packet.rd, exp_c.rd);
                    check("commit_packet.has_dest", commit_packet.has_dest, exp_c.has_dest);
                    if (exp_c.has_dest) begin
                        check("commit_packet.value", commit_packet.value, exp_c.value);
                    end
                end
            end
        end
    end

    // Bus checker, every result is compared by its ROB tag
    initial begin
        forever begin
            @(negedge clock);
            if (!reset && cdb_packet.valid) begin
                bus_results++;
                check("cdb_packet.value", cdb_packet.value, bus_exp[cdb_packet.tag]);
            end
        end
    end

    initial begin
        int                kind, base_d, base_c;
        ooo_pkg::reg_idx_t rd, r1, r2;
        logic [11:0]       imm;
        seed = 23;
        {checks, errors, err_base, dispatched, committed, refused, bus_results} = '0;
        for (int i = 0; i < 32; i++) ref_regs[i] = '0;
        reset = 1'b0;
        dp_packet = '0;
        #2 reset = 1'b1;
        repeat (16) @(posedge clock);
        #2 reset = 1'b0;

        // Immediates seed registers, then independent ALU ops
        for (int i = 1; i < 9; i++) begin
            dispatch(make_inst("addi", 5'(i), 5'd0, 5'd0, 12'(i * 37 - 150)));
        end
        dispatch(make_inst("add", 5'd9, 5'd1, 5'd2, 12'd0));
        dispatch(make_inst("sub", 5'd10, 5'd3, 5'd4, 12'd0));
        dispatch(make_inst("and", 5'd11, 5'd5, 5'd6, 12'd0));
        dispatch(make_inst("or", 5'd12, 5'd7, 5'd8, 12'd0));
        dispatch(make_inst("xor", 5'd13, 5'd1, 5'd8, 12'd0));
        dispatch(make_inst("xori", 5'd14, 5'd2, 5'd0, 12'hfff));
        dispatch(make_inst("ori", 5'd15, 5'd3, 5'd0, 12'h0f0));
        dispatch(make_inst("andi", 5'd16, 5'd4, 5'd0, 12'h07f));
        drain("alu_imm");
        report_test("alu_imm");

        // Chain through x20, every op waits on the one before
        dispatch(make_inst("addi", 5'd20, 5'd1, 5'd0, 12'd5));
        for (int i = 0; i < 12; i++) begin
            dispatch(make_inst(chain_ops[i % 5], 5'd20, 5'd20, 5'((i % 8) + 1), 12'(i * 13)));
        end
        drain("chain");
        report_test("chain");

        // Younger ALU ops finish ahead of the multiplies
        for (int i = 0; i < 6; i++) begin
            dispatch(make_inst("mul", 5'(21 + i % 3), 5'(i + 1), 5'(i + 2), 12'd0));
            dispatch(make_inst("add", 5'd24, 5'd1, 5'd2, 12'd0));
            dispatch(make_inst("xori", 5'd25, 5'd24, 5'd0, 12'(i * 91)));
            dispatch(make_inst("sub", 5'd26, 5'd21, 5'd3, 12'd0));
        end
        drain("mixed");
        report_test("mixed");

        // x0 as destination and as source
        dispatch(make_inst("add", 5'd0, 5'd1, 5'd2, 12'd0));
        dispatch(make_inst("addi", 5'd0, 5'd0, 5'd0, 12'd77));
        dispatch(make_inst("add", 5'd27, 5'd0, 5'd1, 12'd0));
        dispatch(make_inst("mul", 5'd28, 5'd0, 5'd3, 12'd0));
        dispatch(make_inst("ori", 5'd29, 5'd0, 5'd0, 12'hfff));
        dispatch(make_inst("sub", 5'd30, 5'd0, 5'd29, 12'd0));
        drain("x0");
        report_test("x0");

        // Dependent multiplies clog the MUL entries, ALU ops pile up in the ROB
        refused = 0;
        base_d  = dispatched;
        base_c  = committed;
        for (int i = 0; i < 6; i++) dispatch(make_inst("mul", 5'd20, 5'd20, 5'd3, 12'd0));
        for (int i = 1; i < 9; i++) dispatch(make_inst("addi", 5'(i), 5'(i), 5'd0, 12'(i)));
        drain("burst");
        idle(20);
        if (refused == 0) begin
            errors++;
            $display("dispatch_accept never went low during the multiply burst");
        end
        check("commit_count", committed - base_c, dispatched - base_d);
        report_test("burst");

        // Random program, registers x0..x15 for dense dependencies
        for (int n = 0; n < 200; n++) begin
            kind = $unsigned($random(seed)) % 10;
            rd   = 5'($random(seed) & 15);
            r1   = 5'($random(seed) & 15);
            r2   = 5'($random(seed) & 15);
            imm  = 12'($random(seed));
            dispatch(make_inst(mnems[kind], rd, r1, r2, imm));
        end
        drain("random");
        idle(20);
        report_test("random");

        check("commit_count", committed, dispatched);
        check("cdb_count", bus_results, dispatched);
        if (dut.u_properties.failures != 0) begin
            $display("%0d assertion failures in the bound checker", dut.u_properties.failures);
        end
        errors += dut.u_properties.failures;
        $display("checks=%0d errors=%0d dispatched=%0d committed=%0d",
                 checks, errors, dispatched, committed);
        if (errors == 0) $display("ALL CHECKS PASSED");
        else $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/exec_units.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_units (
    input  logic                   clock,
    input  logic                   reset,
    input  ooo_pkg::rs_fu_packet_t alu_issue,
    input  ooo_pkg::rs_fu_packet_t mul_issue,
    output ooo_pkg::cdb_packet_t   cdb_packet,
    output logic                   alu_stall
);

    ooo_pkg::cdb_packet_t     alu_q;                   // ALU stage, holds when it loses
    ooo_pkg::cdb_packet_t     mul_s1, mul_s2, mul_s3;  // Multiplier pipeline
    logic [ooo_pkg::xlen-1:0] alu_result;
    logic                     alu_go, mul_go;

    assign alu_go = alu_issue.valid && alu_issue.unit == ooo_pkg::fu_alu;
    assign mul_go = mul_issue.valid && mul_issue.unit == ooo_pkg::fu_mul;

    always_comb begin
        case (alu_issue.alu_op)
            ooo_pkg::alu_sub: alu_result = alu_issue.a - alu_issue.b;
            ooo_pkg::alu_and: alu_result = alu_issue.a & alu_issue.b;
            ooo_pkg::alu_or:  alu_result = alu_issue.a | alu_issue.b;
            ooo_pkg::alu_xor: alu_result = alu_issue.a ^ alu_issue.b;
            default:          alu_result = alu_issue.a + alu_issue.b;
        endcase
    end

    // Multiplier always owns the bus, ALU waits behind it
    assign cdb_packet = mul_s3.valid ? mul_s3 : alu_q;
    assign alu_stall  = alu_q.valid && mul_s3.valid;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            alu_q <= '0;
        end else if (alu_go) begin
            alu_q.valid <= 1'b1;  // Only issued when the stage is free or draining
            alu_q.tag   <= alu_issue.dest;
            alu_q.value <= alu_result;
        end else if (!mul_s3.valid) begin
            alu_q.valid <= 1'b0;  // Sent this cycle
        end
    end

    // Three stages, product formed in the first
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            mul_s1 <= '0;
            mul_s2 <= '0;
            mul_s3 <= '0;
        end else begin
            mul_s1.valid <= mul_go;
            mul_s1.tag   <= mul_issue.dest;
            mul_s1.value <= mul_issue.a * mul_issue.b;  // Low 32 bits
            mul_s2       <= mul_s1;
            mul_s3       <= mul_s2;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ooo_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module ooo_core (
    input  logic                    clock,
    input  logic                    reset,
    input  ooo_pkg::dp_packet_t     dp_packet,
    output logic                    dispatch_accept,
    output logic                    commit_valid,
    output ooo_pkg::commit_packet_t commit_packet,
    output ooo_pkg::cdb_packet_t    cdb_packet
);

    ooo_pkg::operand_t      src_a, src_b;          // Rename lookups
    ooo_pkg::operand_t      rob_fwd_a, rob_fwd_b;  // ROB forwarding
    ooo_pkg::rob_tag_t      rob_query_a, rob_query_b;
    ooo_pkg::rob_tag_t      rob_tail, commit_tag;
    ooo_pkg::rs_fu_packet_t alu_issue, mul_issue;
    logic                   rob_full, rob_alloc, rename_write, alu_stall;

    rs u_rs (
        .clock           (clock),
        .reset           (reset),
        .dp_packet       (dp_packet),
        .src_a           (src_a),
        .src_b           (src_b),
        .rob_fwd_a       (rob_fwd_a),
        .rob_fwd_b       (rob_fwd_b),
        .rob_tail        (rob_tail),
        .rob_full        (rob_full),
        .cdb_packet      (cdb_packet),
        .alu_stall       (alu_stall),
        .dispatch_accept (dispatch_accept),
        .rob_alloc       (rob_alloc),
        .rob_query_a     (rob_query_a),
        .rob_query_b     (rob_query_b),
        .rename_write    (rename_write),
        .alu_issue       (alu_issue),
        .mul_issue       (mul_issue)
    );

    rename_table u_rename_table (
        .clock         (clock),
        .reset         (reset),
        .rs1_idx       (dp_packet.inst.r.rs1),
        .rs2_idx       (dp_packet.inst.r.rs2),
        .rename_write  (rename_write),
        .rename_rd     (dp_packet.inst.r.rd),
        .rename_tag    (rob_tail),
        .commit_valid  (commit_valid),
        .commit_packet (commit_packet),
        .commit_tag    (commit_tag),
        .src_a         (src_a),
        .src_b         (src_b)
    );

    // rename_write already means "has a destination"
    rob u_rob (
        .clock          (clock),
        .reset          (reset),
        .alloc          (rob_alloc),
        .alloc_rd       (dp_packet.inst.r.rd),
        .alloc_has_dest (rename_write),
        .cdb_packet     (cdb_packet),
        .query_a        (rob_query_a),
        .query_b        (rob_query_b),
        .tail           (rob_tail),
        .full           (rob_full),
        .fwd_a          (rob_fwd_a),
        .fwd_b          (rob_fwd_b),
        .commit_valid   (commit_valid),
        .commit_packet  (commit_packet),
        .commit_tag     (commit_tag)
    );

    exec_units u_exec_units (
        .clock      (clock),
        .reset      (reset),
        .alu_issue  (alu_issue),
        .mul_issue  (mul_issue),
        .cdb_packet (cdb_packet),
        .alu_stall  (alu_stall)
    );

endmodule

`default_nettype wire

// ==== verilog/ooo_pkg.sv ====
`default_nettype none

package ooo_pkg;

    // Machine sizes
    localparam int xlen           = 32;
    localparam int num_arch_regs  = 32;
    localparam int rob_depth      = 8;
    localparam int num_rs_entries = 4;

    typedef logic [$clog2(num_arch_regs)-1:0]  reg_idx_t;
    typedef logic [$clog2(rob_depth)-1:0]      rob_tag_t;  // Plain ROB index
    typedef logic [$clog2(num_rs_entries)-1:0] rs_idx_t;

    // First entry of each unit class, two entries per class
    localparam rs_idx_t rs_alu_base = 2'd0;
    localparam rs_idx_t rs_mul_base = 2'd2;

    // RV32 encodings used here
    localparam logic [6:0] op_reg     = 7'b0110011;
    localparam logic [6:0] op_imm     = 7'b0010011;
    localparam logic [6:0] funct7_mul = 7'b0000001;
    localparam logic [2:0] f3_add     = 3'b000;  // Also SUB and MUL
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    typedef enum logic {
        fu_alu = 1'b0,
        fu_mul = 1'b1
    } fu_type_t;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4
    } alu_op_t;

    // One instruction word, register form or immediate form
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_idx_t   rs2;
            reg_idx_t   rs1;
            logic [2:0] funct3;
            reg_idx_t   rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            reg_idx_t    rs1;
            logic [2:0]  funct3;
            reg_idx_t    rd;
            logic [6:0]  opcode;
        } i;
    } inst_t;

    typedef struct packed {
        logic  valid;
        inst_t inst;
    } dp_packet_t;

    typedef struct packed {
        logic            ready;  // Value holds the operand, else wait on tag
        rob_tag_t        tag;
        logic [xlen-1:0] value;
    } operand_t;

    typedef struct packed {
        logic            valid;
        fu_type_t        unit;
        alu_op_t         alu_op;
        rob_tag_t        dest;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
    } rs_fu_packet_t;

    typedef struct packed {
        logic            valid;
        rob_tag_t        tag;
        logic [xlen-1:0] value;
    } cdb_packet_t;

    typedef struct packed {
        reg_idx_t        rd;
        logic            has_dest;
        logic [xlen-1:0] value;
    } commit_packet_t;

endpackage

`default_nettype wire

// ==== verilog/rename_table.sv ====
`timescale 1ns/1ns
`default_nettype none

module rename_table (
    input  logic                    clock,
    input  logic                    reset,
    input  ooo_pkg::reg_idx_t       rs1_idx,
    input  ooo_pkg::reg_idx_t       rs2_idx,
    input  logic                    rename_write,
    input  ooo_pkg::reg_idx_t       rename_rd,
    input  ooo_pkg::rob_tag_t       rename_tag,
    input  logic                    commit_valid,
    input  ooo_pkg::commit_packet_t commit_packet,
    input  ooo_pkg::rob_tag_t       commit_tag,
    output ooo_pkg::operand_t       src_a,
    output ooo_pkg::operand_t       src_b
);

    logic [ooo_pkg::xlen-1:0] regs [ooo_pkg::num_arch_regs];  // Committed values
    logic                     busy [ooo_pkg::num_arch_regs];
    ooo_pkg::rob_tag_t        tag  [ooo_pkg::num_arch_regs];  // Youngest producer

    always_comb begin
        src_a.ready = (rs1_idx == '0) || !busy[rs1_idx];
        src_a.tag   = tag[rs1_idx];
        src_a.value = regs[rs1_idx];
        src_b.ready = (rs2_idx == '0) || !busy[rs2_idx];
        src_b.tag   = tag[rs2_idx];
        src_b.value = regs[rs2_idx];
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < ooo_pkg::num_arch_regs; i++) begin
                regs[i] <= '0;
                busy[i] <= 1'b0;
                tag[i]  <= '0;
            end
        end else begin
            if (commit_valid && commit_packet.has_dest && commit_packet.rd != '0) begin
                regs[commit_packet.rd] <= commit_packet.value;
                // Only the last producer clears busy
                if (tag[commit_packet.rd] == commit_tag) busy[commit_packet.rd] <= 1'b0;
            end
            if (rename_write && rename_rd != '0) begin
                busy[rename_rd] <= 1'b1;  // Overrides a commit in the same cycle
                tag[rename_rd]  <= rename_tag;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rob.sv ====
`timescale 1ns/1ns
`default_nettype none

module rob (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    alloc,
    input  ooo_pkg::reg_idx_t       alloc_rd,
    input  logic                    alloc_has_dest,
    input  ooo_pkg::cdb_packet_t    cdb_packet,
    input  ooo_pkg::rob_tag_t       query_a,
    input  ooo_pkg::rob_tag_t       query_b,
    output ooo_pkg::rob_tag_t       tail,
    output logic                    full,
    output ooo_pkg::operand_t       fwd_a,
    output ooo_pkg::operand_t       fwd_b,
    output logic                    commit_valid,
    output ooo_pkg::commit_packet_t commit_packet,
    output ooo_pkg::rob_tag_t       commit_tag
);

    logic                    done [ooo_pkg::rob_depth];
    ooo_pkg::commit_packet_t slot [ooo_pkg::rob_depth];  // rd, has_dest, result
    ooo_pkg::rob_tag_t       head;
    logic [$clog2(ooo_pkg::rob_depth):0] count;

    assign full = count == ooo_pkg::rob_depth;

    // Head retires once its result is written
    assign commit_valid  = count != '0 && done[head];
    assign commit_packet = slot[head];
    assign commit_tag    = head;

    // Forwarding for operands whose producer already wrote back
    always_comb begin
        fwd_a.ready = done[query_a];
        fwd_a.tag   = query_a;
        fwd_a.value = slot[query_a].value;
        fwd_b.ready = done[query_b];
        fwd_b.tag   = query_b;
        fwd_b.value = slot[query_b].value;
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < ooo_pkg::rob_depth; i++) begin
                done[i] <= 1'b0;
            end
        end else begin
            if (cdb_packet.valid) done[cdb_packet.tag] <= 1'b1;
            if (alloc) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;  // Wraps at depth
            end
            if (commit_valid) head <= head + 1'b1;
            case ({alloc, commit_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (cdb_packet.valid) slot[cdb_packet.tag].value <= cdb_packet.value;
        if (alloc) begin
            slot[tail].rd       <= alloc_rd;
            slot[tail].has_dest <= alloc_has_dest;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rs.sv ====
`timescale 1ns/1ns
`default_nettype none

module rs (
    input  logic                   clock,
    input  logic                   reset,
    input  ooo_pkg::dp_packet_t    dp_packet,
    input  ooo_pkg::operand_t      src_a,      // From rename table
    input  ooo_pkg::operand_t      src_b,
    input  ooo_pkg::operand_t      rob_fwd_a,  // ROB answer for src tags
    input  ooo_pkg::operand_t      rob_fwd_b,
    input  ooo_pkg::rob_tag_t      rob_tail,
    input  logic                   rob_full,
    input  ooo_pkg::cdb_packet_t   cdb_packet,
    input  logic                   alu_stall,
    output logic                   dispatch_accept,
    output logic                   rob_alloc,
    output ooo_pkg::rob_tag_t      rob_query_a,
    output ooo_pkg::rob_tag_t      rob_query_b,
    output logic                   rename_write,
    output ooo_pkg::rs_fu_packet_t alu_issue,
    output ooo_pkg::rs_fu_packet_t mul_issue
);

    typedef struct packed {
        ooo_pkg::alu_op_t  op;
        ooo_pkg::rob_tag_t dest;
        ooo_pkg::operand_t a;
        ooo_pkg::operand_t b;
    } rs_entry_t;

    logic      busy [ooo_pkg::num_rs_entries];
    rs_entry_t ent  [ooo_pkg::num_rs_entries];

    logic                  ready [ooo_pkg::num_rs_entries];
    logic                  freed [ooo_pkg::num_rs_entries];
    ooo_pkg::inst_t        inst;
    logic                  is_imm, is_mul;
    ooo_pkg::alu_op_t      dp_op;
    logic [ooo_pkg::xlen-1:0] imm_val;
    ooo_pkg::operand_t     cap_a, cap_b;
    logic                  alu_go, mul_go, class_free;
    ooo_pkg::rs_idx_t      alu_sel, mul_sel, lo, hi, alloc_idx;

    // Operand at allocation: rename value, then ROB result, then bus
    function automatic ooo_pkg::operand_t capture(ooo_pkg::operand_t src,
                                                  ooo_pkg::operand_t fwd,
                                                  ooo_pkg::cdb_packet_t cdb);
        ooo_pkg::operand_t res;
        res = src;
        if (!src.ready && fwd.ready) begin
            res.ready = 1'b1;
            res.value = fwd.value;
        end else if (!src.ready && cdb.valid && cdb.tag == src.tag) begin
            res.ready = 1'b1;
            res.value = cdb.value;
        end
        return res;
    endfunction

    // Waiting operand picks up its tag from the bus
    function automatic ooo_pkg::operand_t wake(ooo_pkg::operand_t op,
                                               ooo_pkg::cdb_packet_t cdb);
        ooo_pkg::operand_t res;
        res = op;
        if (!op.ready && cdb.valid && cdb.tag == op.tag) begin
            res.ready = 1'b1;
            res.value = cdb.value;
        end
        return res;
    endfunction

    function automatic ooo_pkg::rs_fu_packet_t issue_pkt(rs_entry_t e,
                                                         ooo_pkg::fu_type_t unit);
        ooo_pkg::rs_fu_packet_t p;
        p.valid  = 1'b1;
        p.unit   = unit;
        p.alu_op = e.op;
        p.dest   = e.dest;
        p.a      = e.a.value;
        p.b      = e.b.value;
        return p;
    endfunction

    // Decode both views of the word
    always_comb begin
        inst    = dp_packet.inst;
        is_imm  = inst.i.opcode == ooo_pkg::op_imm;
        is_mul  = !is_imm && inst.r.funct7 == ooo_pkg::funct7_mul;
        imm_val = {{(ooo_pkg::xlen-12){inst.i.imm12[11]}}, inst.i.imm12};
        case (inst.r.funct3)
            ooo_pkg::f3_add: dp_op = (!is_imm && inst.r.funct7[5]) ? ooo_pkg::alu_sub
                                                                    : ooo_pkg::alu_add;
            ooo_pkg::f3_xor: dp_op = ooo_pkg::alu_xor;
            ooo_pkg::f3_or:  dp_op = ooo_pkg::alu_or;
            ooo_pkg::f3_and: dp_op = ooo_pkg::alu_and;
            default:         dp_op = ooo_pkg::alu_add;
        endcase
    end

    assign rob_query_a = src_a.tag;
    assign rob_query_b = src_b.tag;
    assign cap_a = capture(src_a, rob_fwd_a, cdb_packet);
    always_comb begin
        if (is_imm) begin
            cap_b.ready = 1'b1;  // Immediate is a value from the start
            cap_b.tag   = '0;
            cap_b.value = imm_val;
        end else begin
            cap_b = capture(src_b, rob_fwd_b, cdb_packet);
        end
    end

    // Lowest ready entry per class
    always_comb begin
        for (int i = 0; i < ooo_pkg::num_rs_entries; i++) begin
            ready[i] = busy[i] && ent[i].a.ready && ent[i].b.ready;
        end
        alu_go  = (ready[ooo_pkg::rs_alu_base] || ready[ooo_pkg::rs_alu_base + 1]) && !alu_stall;
        alu_sel = ready[ooo_pkg::rs_alu_base] ? ooo_pkg::rs_alu_base
                                              : ooo_pkg::rs_idx_t'(ooo_pkg::rs_alu_base + 1);
        mul_go  = ready[ooo_pkg::rs_mul_base] || ready[ooo_pkg::rs_mul_base + 1];
        mul_sel = ready[ooo_pkg::rs_mul_base] ? ooo_pkg::rs_mul_base
                                              : ooo_pkg::rs_idx_t'(ooo_pkg::rs_mul_base + 1);
        for (int i = 0; i < ooo_pkg::num_rs_entries; i++) begin
            freed[i] = (alu_go && alu_sel == i) || (mul_go && mul_sel == i);
        end
    end

    assign alu_issue = alu_go ? issue_pkt(ent[alu_sel], ooo_pkg::fu_alu) : '0;
    assign mul_issue = mul_go ? issue_pkt(ent[mul_sel], ooo_pkg::fu_mul) : '0;

    // Allocation in the class of the instruction, issue frees count
    always_comb begin
        lo         = is_mul ? ooo_pkg::rs_mul_base : ooo_pkg::rs_alu_base;
        hi         = ooo_pkg::rs_idx_t'(lo + 1);
        class_free = !busy[lo] || freed[lo] || !busy[hi] || freed[hi];
        alloc_idx  = (!busy[lo] || freed[lo]) ? lo : hi;
    end

    assign dispatch_accept = dp_packet.valid && class_free && !rob_full;
    assign rob_alloc       = dispatch_accept;
    assign rename_write    = dispatch_accept && inst.r.rd != '0;  // x0 never renamed

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < ooo_pkg::num_rs_entries; i++) begin
                busy[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < ooo_pkg::num_rs_entries; i++) begin
                if (freed[i]) busy[i] <= 1'b0;
            end
            if (dispatch_accept) busy[alloc_idx] <= 1'b1;  // Same-cycle reuse wins
        end
    end

    // Operand snoop and capture
    always_ff @(posedge clock) begin
        for (int i = 0; i < ooo_pkg::num_rs_entries; i++) begin
            ent[i].a <= wake(ent[i].a, cdb_packet);
            ent[i].b <= wake(ent[i].b, cdb_packet);
        end
        if (dispatch_accept) begin
            ent[alloc_idx].op   <= dp_op;
            ent[alloc_idx].dest <= rob_tail;
            ent[alloc_idx].a    <= cap_a;
            ent[alloc_idx].b    <= cap_b;
        end
    end

endmodule

`default_nettype wire
